//--- icache_macros.svh
// Cache geometry shared by packages and RTL
// A 4 KiB page holds one way exactly, so sets * block bytes must equal
// the page size for the index to come from the page offset alone
// Ways must be a power of two

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

`define ICACHE_WAYS        2
`define ICACHE_SETS        256
`define ICACHE_BLOCK_BITS  128
`define ICACHE_WORD_BITS   32
`define ICACHE_PTAG_BITS   20
`define ICACHE_PAGE_BITS   12

`endif

//--- icache_addr_pkg.sv
// Address field types for the instruction cache
// Index and word select are cut from the page offset only, so the
// cache is virtually indexed with no aliasing across pages

`default_nettype none

`include "icache_macros.svh"

package icache_addr_pkg;

  localparam int unsigned block_off_bits_lp = $clog2(`ICACHE_BLOCK_BITS / 8);
  localparam int unsigned word_off_bits_lp  = $clog2(`ICACHE_WORD_BITS / 8);

  typedef logic [`ICACHE_PAGE_BITS-1:0]                        page_off_t;
  typedef logic [$clog2(`ICACHE_SETS)-1:0]                     index_t;
  typedef logic [$clog2(`ICACHE_BLOCK_BITS / `ICACHE_WORD_BITS)-1:0] word_sel_t;
  typedef logic [`ICACHE_PTAG_BITS-1:0]                        ptag_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0]                     way_id_t;

  // Set index sits just above the block offset
  function automatic index_t get_index(page_off_t off);
    return off[block_off_bits_lp +: $bits(index_t)];
  endfunction

  function automatic word_sel_t get_word_sel(page_off_t off);
    return off[word_off_bits_lp +: $bits(word_sel_t)];
  endfunction

endpackage

`default_nettype wire

//--- icache_line_pkg.sv
// Cache line payload types
// A block is a packed array of instruction words, word 0 in the low bits

`default_nettype none

`include "icache_macros.svh"

package icache_line_pkg;

  localparam int unsigned words_per_block_lp = `ICACHE_BLOCK_BITS / `ICACHE_WORD_BITS;

  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

  // Indexing a block by word number gives one instruction
  typedef word_t [words_per_block_lp-1:0] block_t;

endpackage

`default_nettype wire

//--- way_if.sv
// Lookup and fill traffic of one cache way
// Read and write requests never share a cycle; the control side makes sure

`timescale 1ns/1ns
`default_nettype none

interface way_if;
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  // Fetch read, tag arrives a cycle later
  logic   rd_v;
  index_t rd_index;
  ptag_t  lookup_tag;

  // Fill or invalidate
  logic   wr_v;
  logic   wr_valid;
  index_t wr_index;
  ptag_t  wr_tag;
  block_t wr_block;

  // Way response
  logic   hit;
  block_t rd_block;

  modport ctrl (output rd_v, rd_index, lookup_tag, wr_v, wr_valid, wr_index, wr_tag, wr_block);
  modport way  (input rd_v, rd_index, lookup_tag, wr_v, wr_valid, wr_index, wr_tag, wr_block,
                output hit, rd_block);
  modport sel  (input hit, rd_block);

endinterface

`default_nettype wire

//--- sync_ram.sv
// Single port synchronous RAM, one access per cycle
// Read data appears the cycle after v_i and holds until the next read
// A write leaves the read output untouched
// els_p must not exceed the range of index_t

`timescale 1ns/1ns
`default_nettype none

module sync_ram
  #(parameter type payload_t = logic
  , parameter int unsigned els_p = 256
  )
  (input  logic                    clk_i
  , input  logic                   v_i
  , input  logic                   w_i
  , input  icache_addr_pkg::index_t addr_i
  , input  payload_t               data_i
  , output payload_t               data_o
  );

  payload_t mem [els_p];

  always_ff @(posedge clk_i)
  begin
    if (v_i & w_i)
    begin
      mem[addr_i] <= data_i;
    end
    else if (v_i)
    begin
      data_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- icache_way.sv
// One cache way: tag RAM, data RAM and per-set valid bits
// hit is combinational on lookup_tag in the cycle after the read
// An invalidate only clears the valid bit, both RAMs stay idle

`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_way
  (input  logic clk_i
  , input logic reset_i
  , way_if.way  port
  );
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  logic [`ICACHE_SETS-1:0] valid_r;
  logic                    valid_rd_r;
  logic                    ram_w;
  logic                    ram_v;
  index_t                  ram_addr;
  ptag_t                   tag_lo;

  assign ram_w    = port.wr_v & port.wr_valid;
  assign ram_v    = port.rd_v | ram_w;
  assign ram_addr = ram_w ? port.wr_index : port.rd_index;

  sync_ram #(.payload_t(ptag_t), .els_p(`ICACHE_SETS)) tag_ram
    (.clk_i  (clk_i)
    , .v_i   (ram_v)
    , .w_i   (ram_w)
    , .addr_i(ram_addr)
    , .data_i(port.wr_tag)
    , .data_o(tag_lo)
    );

  sync_ram #(.payload_t(block_t), .els_p(`ICACHE_SETS)) data_ram
    (.clk_i  (clk_i)
    , .v_i   (ram_v)
    , .w_i   (ram_w)
    , .addr_i(ram_addr)
    , .data_i(port.wr_block)
    , .data_o(port.rd_block)
    );

  // Valid bits, sampled alongside the RAM read
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r    <= '0;
      valid_rd_r <= 1'b0;
    end
    else
    begin
      if (port.wr_v)
        valid_r[port.wr_index] <= port.wr_valid;
      if (port.rd_v)
        valid_rd_r <= valid_r[port.rd_index];
    end
  end

  assign port.hit = valid_rd_r & (tag_lo == port.lookup_tag);

endmodule

`default_nettype wire

//--- lookup_ctrl.sv
// Front end of the cache: accepts fetches and fills, drives every way
// A fill always wins the cycle; fetch_ready_o drops while fill_v_i is high
// ptag_i is passed straight through to the ways during the tag-lookup stage

`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module lookup_ctrl
  (input  logic                        clk_i
  , input  logic                       reset_i
  , input  logic                       fetch_v_i
  , input  icache_addr_pkg::page_off_t fetch_off_i
  , output logic                       fetch_ready_o
  , input  icache_addr_pkg::ptag_t     ptag_i
  , input  logic                       fill_v_i
  , input  icache_addr_pkg::way_id_t   fill_way_i
  , input  icache_addr_pkg::page_off_t fill_off_i
  , input  icache_addr_pkg::ptag_t     fill_tag_i
  , input  icache_line_pkg::block_t    fill_block_i
  , input  logic                       fill_inval_i
  , output logic                       tl_v_o
  , output icache_addr_pkg::word_sel_t tl_word_o
  , way_if.ctrl                        ways [`ICACHE_WAYS]
  );
  import icache_addr_pkg::*;

  logic      fetch_acc;
  logic      tl_v_r;
  word_sel_t tl_word_r;

  assign fetch_ready_o = ~fill_v_i;
  assign fetch_acc     = fetch_v_i & fetch_ready_o;

  ////////////////////////////////////////////////////////////
  // Way requests
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < `ICACHE_WAYS; i++)
  begin : g_way_req
    assign ways[i].rd_v       = fetch_acc;
    assign ways[i].rd_index   = get_index(fetch_off_i);
    assign ways[i].lookup_tag = ptag_i;

    // Only the named way sees the fill
    assign ways[i].wr_v     = fill_v_i & (fill_way_i == way_id_t'(i));
    assign ways[i].wr_valid = ~fill_inval_i;
    assign ways[i].wr_index = get_index(fill_off_i);
    assign ways[i].wr_tag   = fill_tag_i;
    assign ways[i].wr_block = fill_block_i;
  end

  ////////////////////////////////////////////////////////////
  // Tag-lookup stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else
      tl_v_r <= fetch_acc;
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_acc)
      tl_word_r <= get_word_sel(fetch_off_i);
  end

  assign tl_v_o    = tl_v_r;
  assign tl_word_o = tl_word_r;

endmodule

`default_nettype wire

//--- way_select.sv
// Tag-verify stage: merges way hits and registers the result
// Assumes at most one way hits, so the hitting blocks are simply ORed
// Results are single-cycle pulses with no back-pressure

`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module way_select
  (input  logic                        clk_i
  , input  logic                       reset_i
  , input  logic                       tl_v_i
  , input  icache_addr_pkg::word_sel_t tl_word_i
  , way_if.sel                         ways [`ICACHE_WAYS]
  , output icache_line_pkg::word_t     data_o
  , output logic                       data_v_o
  , output logic                       miss_v_o
  );
  import icache_line_pkg::*;

  logic [`ICACHE_WAYS-1:0] hit_vec;
  block_t                  way_blocks [`ICACHE_WAYS];
  block_t                  merged;
  logic                    any_hit;
  word_t                   data_r;
  logic                    data_v_r;
  logic                    miss_v_r;

  for (genvar i = 0; i < `ICACHE_WAYS; i++)
  begin : g_way_hit
    assign hit_vec[i]    = ways[i].hit;
    assign way_blocks[i] = ways[i].hit ? ways[i].rd_block : '0;
  end

  always_comb
  begin
    merged = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++)
      merged |= way_blocks[i];
  end

  assign any_hit = |hit_vec;

  // Result flags
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_v_r <= 1'b0;
      miss_v_r <= 1'b0;
    end
    else
    begin
      data_v_r <= tl_v_i & any_hit;
      miss_v_r <= tl_v_i & ~any_hit;
    end
  end

  // Zero word on a miss
  always_ff @(posedge clk_i)
  begin
    if (tl_v_i)
      data_r <= any_hit ? merged[tl_word_i] : '0;
  end

  assign data_o   = data_r;
  assign data_v_o = data_v_r;
  assign miss_v_o = miss_v_r;

endmodule

`default_nettype wire

//--- icache_top.sv
// Two-way physically tagged L1 instruction cache read pipeline
// Fetch result pulses two cycles after acceptance, no miss requests
// are issued; an external engine fills or invalidates by set and way

`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module icache_top
  (input  logic                        clk_i
  , input  logic                       reset_i
  , input  logic                       fetch_v_i
  , input  icache_addr_pkg::page_off_t fetch_off_i
  , output logic                       fetch_ready_o
  , input  icache_addr_pkg::ptag_t     ptag_i
  , input  logic                       fill_v_i
  , input  icache_addr_pkg::way_id_t   fill_way_i
  , input  icache_addr_pkg::page_off_t fill_off_i
  , input  icache_addr_pkg::ptag_t     fill_tag_i
  , input  icache_line_pkg::block_t    fill_block_i
  , input  logic                       fill_inval_i
  , output icache_line_pkg::word_t     data_o
  , output logic                       data_v_o
  , output logic                       miss_v_o
  );
  import icache_addr_pkg::*;

  logic      tl_v;
  word_sel_t tl_word;

  way_if ways [`ICACHE_WAYS] ();

  lookup_ctrl i_ctrl
    (.clk_i         (clk_i)
    , .reset_i      (reset_i)
    , .fetch_v_i    (fetch_v_i)
    , .fetch_off_i  (fetch_off_i)
    , .fetch_ready_o(fetch_ready_o)
    , .ptag_i       (ptag_i)
    , .fill_v_i     (fill_v_i)
    , .fill_way_i   (fill_way_i)
    , .fill_off_i   (fill_off_i)
    , .fill_tag_i   (fill_tag_i)
    , .fill_block_i (fill_block_i)
    , .fill_inval_i (fill_inval_i)
    , .tl_v_o       (tl_v)
    , .tl_word_o    (tl_word)
    , .ways         (ways)
    );

  for (genvar i = 0; i < `ICACHE_WAYS; i++)
  begin : g_way
    icache_way i_way
      (.clk_i   (clk_i)
      , .reset_i(reset_i)
      , .port   (ways[i])
      );
  end

  way_select i_sel
    (.clk_i    (clk_i)
    , .reset_i (reset_i)
    , .tl_v_i  (tl_v)
    , .tl_word_i(tl_word)
    , .ways    (ways)
    , .data_o  (data_o)
    , .data_v_o(data_v_o)
    , .miss_v_o(miss_v_o)
    );

endmodule

`default_nettype wire

//--- tb_icache.sv
// Testbench for the two-way instruction cache read pipeline
// Expected results come from a reference model of valid, tag and block
// per set and way, updated by every fill the testbench applies
// Random fills never give both ways of one set the same valid tag

`timescale 1ns/1ns
`default_nettype none

`include "icache_macros.svh"

module tb_icache;
  import icache_addr_pkg::*;
  import icache_line_pkg::*;

  logic      clk_i;
  logic      reset_i;
  logic      fetch_v_i;
  page_off_t fetch_off_i;
  logic      fetch_ready_o;
  ptag_t     ptag_i;
  logic      fill_v_i;
  way_id_t   fill_way_i;
  page_off_t fill_off_i;
  ptag_t     fill_tag_i;
  block_t    fill_block_i;
  logic      fill_inval_i;
  word_t     data_o;
  logic      data_v_o;
  logic      miss_v_o;

  // Reference model
  logic   m_valid [`ICACHE_WAYS][`ICACHE_SETS];
  ptag_t  m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  block_t m_block [`ICACHE_WAYS][`ICACHE_SETS];

  // Hit flag above the expected word
  logic [`ICACHE_WORD_BITS:0] exp_q [$];
  ptag_t pend_tag;
  int    chk_cnt;
  int    err_cnt;
  int    test_num;
  int    chk_base;
  int    err_base;

  localparam ptag_t tag_a_lp = 20'hABCDE;
  localparam ptag_t tag_b_lp = 20'h12345;

  icache_top i_dut
    (.clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .fetch_v_i    (fetch_v_i)
    , .fetch_off_i  (fetch_off_i)
    , .fetch_ready_o(fetch_ready_o)
    , .ptag_i       (ptag_i)
    , .fill_v_i     (fill_v_i)
    , .fill_way_i   (fill_way_i)
    , .fill_off_i   (fill_off_i)
    , .fill_tag_i   (fill_tag_i)
    , .fill_block_i (fill_block_i)
    , .fill_inval_i (fill_inval_i)
    , .data_o       (data_o)
    , .data_v_o     (data_v_o)
    , .miss_v_o     (miss_v_o)
    );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Reference lookup: index is offset bits 11..4, word is 3..2
  ////////////////////////////////////////////////////////////
  function automatic logic [`ICACHE_WORD_BITS:0] ref_lookup(page_off_t off, ptag_t tag);
    logic [7:0] idx;
    logic [1:0] ws;
    logic [`ICACHE_WORD_BITS:0] r;
    idx = off[11:4];
    ws  = off[3:2];
    r   = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (m_valid[w][idx] && m_tag[w][idx] == tag)
        r = {1'b1, m_block[w][idx][ws]};
    return r;
  endfunction

  function automatic block_t rand_block();
    block_t b;
    for (int i = 0; i < words_per_block_lp; i++)
      b[i] = word_t'($urandom());
    return b;
  endfunction

  // One clock cycle of stimulus; a fill blocks the fetch of the same cycle
  task automatic drive_cycle(input logic fv, input page_off_t foff, input ptag_t ftag,
                             input logic lv, input way_id_t lway, input page_off_t loff,
                             input ptag_t ltag, input block_t lblk, input logic linv);
    @(posedge clk_i);
    #1;
    ptag_i       = pend_tag;
    fetch_v_i    = fv;
    fetch_off_i  = foff;
    fill_v_i     = lv;
    fill_way_i   = lway;
    fill_off_i   = loff;
    fill_tag_i   = ltag;
    fill_block_i = lblk;
    fill_inval_i = linv;
    if (lv)
    begin
      m_valid[lway][loff[11:4]] = ~linv;
      if (!linv)
      begin
        m_tag[lway][loff[11:4]]   = ltag;
        m_block[lway][loff[11:4]] = lblk;
      end
    end
    else if (fv)
    begin
      exp_q.push_back(ref_lookup(foff, ftag));
      pend_tag = ftag;
    end
    #1;
    chk_cnt++;
    if (fetch_ready_o !== ~lv)
    begin
      $display("mismatch fetch_ready_o exp %h got %h", ~lv, fetch_ready_o);
      err_cnt++;
    end
  endtask

  task automatic fetch(input page_off_t off, input ptag_t tag);
    drive_cycle(1'b1, off, tag, 1'b0, '0, '0, '0, '0, 1'b0);
  endtask

  task automatic fill(input way_id_t way, input page_off_t off, input ptag_t tag,
                      input block_t blk, input logic inv);
    drive_cycle(1'b0, '0, '0, 1'b1, way, off, tag, blk, inv);
  endtask

  // Idle until every queued result has come back
  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10)
    begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, '0, '0, 1'b0);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("timeout while %0d fetch results were still missing", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    test_num++;
    $display("test %0d %-26s checks %0d errors %0d", test_num, name,
             chk_cnt - chk_base, err_cnt - err_base);
    chk_base = chk_cnt;
    err_base = err_cnt;
  endtask

  // Result checker, sampled mid-cycle
  always @(negedge clk_i)
  begin
    logic [`ICACHE_WORD_BITS:0] exp;
    if (reset_i === 1'b0 && (data_v_o === 1'b1 || miss_v_o === 1'b1))
    begin
      chk_cnt++;
      if (data_v_o === 1'b1 && miss_v_o === 1'b1)
      begin
        $display("data_v_o and miss_v_o were high in the same cycle");
        err_cnt++;
      end
      else if (exp_q.size() == 0)
      begin
        $display("result pulse arrived with no fetch outstanding");
        err_cnt++;
      end
      else
      begin
        exp = exp_q.pop_front();
        if (data_v_o !== exp[`ICACHE_WORD_BITS])
        begin
          $display("mismatch data_v_o exp %h got %h", exp[`ICACHE_WORD_BITS], data_v_o);
          err_cnt++;
        end
        else if (data_o !== exp[`ICACHE_WORD_BITS-1:0])
        begin
          $display("mismatch data_o exp %h got %h", exp[`ICACHE_WORD_BITS-1:0], data_o);
          err_cnt++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    block_t    blk_a;
    block_t    blk_b;
    int        acc;
    int        cyc;
    logic [7:0] idx;
    way_id_t   lway;
    ptag_t     ltag;
    ptag_t     ftag;
    logic      lv;
    page_off_t foff;

    void'($urandom(32'h900d));
    reset_i = 1'b1;
    fetch_v_i = 1'b0;
    fetch_off_i = '0;
    ptag_i = '0;
    fill_v_i = 1'b0;
    fill_way_i = '0;
    fill_off_i = '0;
    fill_tag_i = '0;
    fill_block_i = '0;
    fill_inval_i = 1'b0;
    pend_tag = '0;
    chk_cnt = 0;
    err_cnt = 0;
    test_num = 0;
    chk_base = 0;
    err_base = 0;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_block[w][s] = '0;
      end

    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    repeat (8) fetch(page_off_t'($urandom()), ptag_t'($urandom()));
    finish_test("cold misses");

    blk_a = rand_block();
    fill('0, 12'h5A0, tag_a_lp, blk_a, 1'b0);
    for (int ws = 0; ws < 4; ws++)
      fetch(page_off_t'(12'h5A0 | (ws << 2)), tag_a_lp);
    finish_test("fill then hit all words");

    fetch(12'h5A4, tag_a_lp ^ 20'h00080);
    fetch(12'h5B0, tag_a_lp);
    finish_test("tag and index misses");

    blk_b = rand_block();
    fill(1'b1, 12'h5A0, tag_b_lp, blk_b, 1'b0);
    for (int ws = 0; ws < 4; ws++)
    begin
      fetch(page_off_t'(12'h5A0 | (ws << 2)), tag_a_lp);
      fetch(page_off_t'(12'h5A0 | (ws << 2)), tag_b_lp);
    end
    finish_test("two ways one set");

    fill('0, 12'h5A0, '0, '0, 1'b1);
    fetch(12'h5A4, tag_a_lp);
    fetch(12'h5A8, tag_b_lp);
    finish_test("invalidate one way");

    // Small index range so fills and fetches collide often
    acc = 0;
    cyc = 0;
    while (acc < 200 && cyc < 2000)
    begin
      idx  = 8'($urandom() & 32'hF);
      lway = way_id_t'($urandom());
      ftag = ($urandom() & 1) ? m_tag[lway][idx] : ptag_t'(32'h40000 | ($urandom() & 3));
      foff = page_off_t'({idx, 4'h0} | ($urandom() & 32'hF));
      lv   = ($urandom() % 5) == 0;
      if (lv)
      begin
        lway = way_id_t'($urandom());
        ltag = ptag_t'(32'h40000 | ($urandom() & 3));
        if (m_valid[~lway][idx] && m_tag[~lway][idx] == ltag)
          ltag = ltag ^ 20'h1;
        drive_cycle(1'b1, foff, ftag, 1'b1, lway, page_off_t'({idx, 4'h0}), ltag,
                    rand_block(), ($urandom() % 8) == 0);
      end
      else
      begin
        fetch(foff, ftag);
        acc++;
      end
      cyc++;
    end
    if (acc < 200)
    begin
      $display("random phase gave up after %0d of 200 fetches", acc);
      err_cnt++;
    end
    finish_test("random fetches and fills");

    $display("tests %0d checks %0d errors %0d", test_num, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_top.f
+incdir+.
icache_addr_pkg.sv
icache_line_pkg.sv
way_if.sv
sync_ram.sv
icache_way.sv
lookup_ctrl.sv
way_select.sv
icache_top.sv
tb_icache.sv

//--- Makefile
# Verilator build for the instruction cache and its testbench
# Variables may be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= icache_top.f
RTL_TOP   ?= icache_top
TB_TOP    ?= tb_icache
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0
SIM_BIN   ?= sim_$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR) -o $(SIM_BIN)
	@out=$$(./$(OBJ_DIR)/$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
